/* Makefile */
TOP := tb_fpu
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sources.f

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/tb_fpu_checks.svh */
// ==========================================================================
// compare tasks and error counters for the add/subtract unit testbench
// ==========================================================================

int checks = 0;
int errors = 0;

task automatic check_result(input fp_fmt_pkg::fp32_t got, input fp_fmt_pkg::fp32_t want,
                            input string what);
    checks++;
    if (got !== want) begin
        errors++;
        $display("Fail at %0d ns: %s result %h, expected %h", $time, what, got, want);
    end
endtask

task automatic check_flags(input fpu_pipe_pkg::fflags_t got,
                           input fpu_pipe_pkg::fflags_t want, input string what);
    checks++;
    if (got !== want) begin
        errors++;
        $display("Fail at %0d ns: %s flags %b, expected %b", $time, what, got, want);
    end
endtask

// single control lines such as valid and taken
task automatic match_bit(input logic got, input logic want, input string what);
    checks++;
    if (got !== want) begin
        errors++;
        $display("Fail at %0d ns: %s is %b, expected %b", $time, what, got, want);
    end
endtask

/* bench/tb_fpu.sv */
// ==========================================================================
// testbench for the single-precision add/subtract unit
// directed tests for arithmetic, rounding, specials and the handshake
// ==========================================================================

module tb_fpu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 20;
    localparam int SAMPLE_DLY   = 5;
    localparam int RESET_CYCLES = 8;
    // operations issued, the held and the refused request included
    localparam int N_OPS        = 15;
    localparam int CYCLE_LIMIT  = 20 * N_OPS + RESET_CYCLES;

    localparam logic [6:0] OPC_ADD = 7'b0000001;
    localparam logic [6:0] OPC_SUB = 7'b0000010;
    localparam logic [6:0] OPC_BAD = 7'b0000100;

    localparam fp_fmt_pkg::fp32_t ZERO     = 32'h0000_0000;
    localparam fp_fmt_pkg::fp32_t ONE      = 32'h3F80_0000;
    localparam fp_fmt_pkg::fp32_t ONE_UP   = 32'h3F80_0001;
    localparam fp_fmt_pkg::fp32_t HALF_ULP = 32'h3380_0000;
    localparam fp_fmt_pkg::fp32_t ONE_HALF = 32'h3FC0_0000;
    localparam fp_fmt_pkg::fp32_t TWO      = 32'h4000_0000;
    localparam fp_fmt_pkg::fp32_t THREE    = 32'h4040_0000;
    localparam fp_fmt_pkg::fp32_t THREE_H  = 32'h4060_0000;
    localparam fp_fmt_pkg::fp32_t FIVE     = 32'h40A0_0000;
    localparam fp_fmt_pkg::fp32_t MAX_FIN  = 32'h7F7F_FFFF;
    localparam fp_fmt_pkg::fp32_t INF      = 32'h7F80_0000;
    localparam fp_fmt_pkg::fp32_t SNAN     = 32'h7F80_0001;
    localparam fp_fmt_pkg::fp32_t QNAN     = 32'h7FC0_0000;

    // NV DZ OF UF NX
    localparam fpu_pipe_pkg::fflags_t NO_FLAGS = 5'b00000;
    localparam fpu_pipe_pkg::fflags_t FL_NV    = 5'b10000;
    localparam fpu_pipe_pkg::fflags_t FL_NX    = 5'b00001;
    localparam fpu_pipe_pkg::fflags_t FL_OF_NX = 5'b00101;

    logic                  clk;
    logic                  rst;
    logic                  req_valid_i;
    logic [6:0]            fp_instruction_i;
    fpu_pipe_pkg::rm_e     rm_i;
    fpu_pipe_pkg::rm_e     csr_rm_i;
    fp_fmt_pkg::fp32_t     rs1_i;
    fp_fmt_pkg::fp32_t     rs2_i;
    logic                  req_taken_o;
    fp_fmt_pkg::fp32_t     result_o;
    fpu_pipe_pkg::fflags_t fflags_o;
    logic                  result_valid_o;
    int                    cycles = 0;

    `include "tb_fpu_checks.svh"

    fpu_top uut (
        .clk              (clk),
        .rst              (rst),
        .req_valid_i      (req_valid_i),
        .fp_instruction_i (fp_instruction_i),
        .rm_i             (rm_i),
        .csr_rm_i         (csr_rm_i),
        .rs1_i            (rs1_i),
        .rs2_i            (rs2_i),
        .req_taken_o      (req_taken_o),
        .result_o         (result_o),
        .fflags_o         (fflags_o),
        .result_valid_o   (result_valid_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ======================================================================
    // request and response helpers
    // ======================================================================

    // returns right after the take edge
    task automatic take_request(input logic [6:0] op, input fpu_pipe_pkg::rm_e rm,
                                input fp_fmt_pkg::fp32_t a, input fp_fmt_pkg::fp32_t b);
        @(negedge clk);
        req_valid_i      = 1'b1;
        fp_instruction_i = op;
        rm_i             = rm;
        rs1_i            = a;
        rs2_i            = b;
        #SAMPLE_DLY;
        while (!req_taken_o) begin
            @(negedge clk);
            #SAMPLE_DLY;
        end
        @(posedge clk);
    endtask

    // result is due 4 edges after the take and stays valid for one cycle
    task automatic expect_result(input fp_fmt_pkg::fp32_t want,
                                 input fpu_pipe_pkg::fflags_t want_flags, input string what);
        int k;
        for (k = 0; k < 4; k++) begin
            @(negedge clk);
            if (k == 0) begin
                req_valid_i = 1'b0;
            end
            #SAMPLE_DLY;
            match_bit(result_valid_o, 1'b0, {what, " valid early"});
        end
        @(negedge clk);
        #SAMPLE_DLY;
        match_bit(result_valid_o, 1'b1, {what, " valid"});
        check_result(result_o, want, what);
        check_flags(fflags_o, want_flags, what);
        @(negedge clk);
        #SAMPLE_DLY;
        match_bit(result_valid_o, 1'b0, {what, " valid after one cycle"});
    endtask

    task automatic run_op(input logic [6:0] op, input fpu_pipe_pkg::rm_e rm,
                          input fp_fmt_pkg::fp32_t a, input fp_fmt_pkg::fp32_t b,
                          input fp_fmt_pkg::fp32_t want,
                          input fpu_pipe_pkg::fflags_t want_flags, input string what);
        take_request(op, rm, a, b);
        expect_result(want, want_flags, what);
    endtask

    // ======================================================================
    // directed tests
    // ======================================================================

    task automatic idle_after_reset();
        #SAMPLE_DLY;
        match_bit(result_valid_o, 1'b0, "valid after reset");
        match_bit(req_taken_o, 1'b0, "taken after reset");
        check_result(result_o, ZERO, "result after reset");
    endtask

    task automatic exact_sums();
        run_op(OPC_ADD, fpu_pipe_pkg::RNE, ONE, TWO, THREE, NO_FLAGS, "1.0 + 2.0");
        run_op(OPC_SUB, fpu_pipe_pkg::RNE, FIVE, ONE_HALF, THREE_H, NO_FLAGS, "5.0 - 1.5");
        run_op(OPC_SUB, fpu_pipe_pkg::RNE, TWO, TWO, ZERO, NO_FLAGS, "2.0 - 2.0");
    endtask

    // 1.0 + 2^-24 lies exactly halfway between two neighbours
    task automatic rounding_tie();
        run_op(OPC_ADD, fpu_pipe_pkg::RNE, ONE, HALF_ULP, ONE, FL_NX, "tie RNE");
        run_op(OPC_ADD, fpu_pipe_pkg::RTZ, ONE, HALF_ULP, ONE, FL_NX, "tie RTZ");
        run_op(OPC_ADD, fpu_pipe_pkg::RUP, ONE, HALF_ULP, ONE_UP, FL_NX, "tie RUP");
        run_op(OPC_ADD, fpu_pipe_pkg::RMM, ONE, HALF_ULP, ONE_UP, FL_NX, "tie RMM");
        @(negedge clk);
        csr_rm_i = fpu_pipe_pkg::RUP;
        run_op(OPC_ADD, fpu_pipe_pkg::DYN, ONE, HALF_ULP, ONE_UP, FL_NX, "tie DYN as RUP");
    endtask

    task automatic special_operands();
        run_op(OPC_ADD, fpu_pipe_pkg::RNE, SNAN, ONE, QNAN, FL_NV, "NaN + 1.0");
        run_op(OPC_SUB, fpu_pipe_pkg::RNE, INF, INF, QNAN, FL_NV, "inf - inf");
        run_op(OPC_ADD, fpu_pipe_pkg::RNE, INF, ONE, INF, NO_FLAGS, "inf + 1.0");
    endtask

    task automatic overflow_to_inf();
        run_op(OPC_ADD, fpu_pipe_pkg::RNE, MAX_FIN, MAX_FIN, INF, FL_OF_NX, "max + max");
    endtask

    task automatic back_to_back();
        int k;
        take_request(OPC_ADD, fpu_pipe_pkg::RNE, ONE, TWO);
        // second request held through the busy cycles
        @(negedge clk);
        fp_instruction_i = OPC_SUB;
        rs1_i            = FIVE;
        rs2_i            = ONE_HALF;
        for (k = 0; k < 4; k++) begin
            #SAMPLE_DLY;
            match_bit(req_taken_o, 1'b0, "held request taken while busy");
            @(negedge clk);
        end
        #SAMPLE_DLY;
        match_bit(result_valid_o, 1'b1, "first of back-to-back valid");
        check_result(result_o, THREE, "first of back-to-back");
        match_bit(req_taken_o, 1'b1, "held request taken at done");
        @(posedge clk);
        expect_result(THREE_H, NO_FLAGS, "second of back-to-back");
    endtask

    task automatic unsupported_opcode();
        int k;
        @(negedge clk);
        req_valid_i      = 1'b1;
        fp_instruction_i = OPC_BAD;
        rm_i             = fpu_pipe_pkg::RNE;
        rs1_i            = ONE;
        rs2_i            = TWO;
        for (k = 0; k < 10; k++) begin
            #SAMPLE_DLY;
            match_bit(req_taken_o, 1'b0, "unsupported opcode taken");
            @(negedge clk);
        end
        req_valid_i = 1'b0;
    endtask

    initial begin
        clk              = 1'b0;
        rst              = 1'b1;
        req_valid_i      = 1'b0;
        fp_instruction_i = '0;
        rm_i             = fpu_pipe_pkg::RNE;
        csr_rm_i         = fpu_pipe_pkg::RNE;
        rs1_i            = '0;
        rs2_i            = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        idle_after_reset();
        exact_sums();
        rounding_tie();
        special_operands();
        overflow_to_inf();
        back_to_back();
        unsupported_opcode();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* design/fp_add_align.sv */
// ==========================================================================
// first adder stage that unpacks, classifies specials, orders and aligns
// ==========================================================================

module fp_add_align (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        valid_i,
    input  fpu_pipe_pkg::add_req_t      req_i,
    output logic                        valid_o,
    output fpu_pipe_pkg::align_stage_t  stage_o
);

    fp_fmt_pkg::fp32_t               b_eff;
    fp_fmt_pkg::exp_t                ea;
    fp_fmt_pkg::exp_t                eb;
    fp_fmt_pkg::exp_t                ea_eff;
    fp_fmt_pkg::exp_t                eb_eff;
    fp_fmt_pkg::exp_t                diff;
    fp_fmt_pkg::man_t                ma;
    fp_fmt_pkg::man_t                mb;
    fp_fmt_pkg::sig_t                sa;
    fp_fmt_pkg::sig_t                sb;
    fp_fmt_pkg::sig_t                sig_small;
    logic                            a_nan;
    logic                            b_nan;
    logic                            a_inf;
    logic                            b_inf;
    logic                            a_ge_b;
    logic [2*fp_fmt_pkg::WIDE_W-1:0] shift_full;
    fp_fmt_pkg::wide_t               small_sh;
    fpu_pipe_pkg::spec_t             spec;

    // subtraction runs as addition with b negated
    assign b_eff = {req_i.b[31] ^ req_i.sub, req_i.b[30:0]};

    assign ea = req_i.a[fp_fmt_pkg::MAN_W +: fp_fmt_pkg::EXP_W];
    assign eb = b_eff[fp_fmt_pkg::MAN_W +: fp_fmt_pkg::EXP_W];
    assign ma = req_i.a[fp_fmt_pkg::MAN_W-1:0];
    assign mb = b_eff[fp_fmt_pkg::MAN_W-1:0];

    assign a_nan = (ea == fp_fmt_pkg::EXP_MAX) && (ma != '0);
    assign b_nan = (eb == fp_fmt_pkg::EXP_MAX) && (mb != '0);
    assign a_inf = (ea == fp_fmt_pkg::EXP_MAX) && (ma == '0);
    assign b_inf = (eb == fp_fmt_pkg::EXP_MAX) && (mb == '0);

    // subnormals get a hidden 0 and exponent 1
    assign sa     = {ea != '0, ma};
    assign sb     = {eb != '0, mb};
    assign ea_eff = (ea == '0) ? fp_fmt_pkg::exp_t'(1) : ea;
    assign eb_eff = (eb == '0) ? fp_fmt_pkg::exp_t'(1) : eb;

    assign a_ge_b    = ({ea, ma} >= {eb, mb});
    assign sig_small = a_ge_b ? sb : sa;
    assign diff      = a_ge_b ? (ea_eff - eb_eff) : (eb_eff - ea_eff);

    // ======================================================================
    // alignment shift with sticky collapse
    // ======================================================================
    assign shift_full = {1'b0, sig_small, {fp_fmt_pkg::GRS_W{1'b0}},
                         {fp_fmt_pkg::WIDE_W{1'b0}}} >> diff;

    always_comb begin
        if (diff >= fp_fmt_pkg::WIDE_W) begin
            small_sh = fp_fmt_pkg::wide_t'(|sig_small);
        end else begin
            small_sh = shift_full[2*fp_fmt_pkg::WIDE_W-1 -: fp_fmt_pkg::WIDE_W]
                     | fp_fmt_pkg::wide_t'(|shift_full[fp_fmt_pkg::WIDE_W-1:0]);
        end
    end

    always_comb begin
        spec = '0;
        if (a_nan || b_nan || (a_inf && b_inf && (req_i.a[31] != b_eff[31]))) begin
            spec.take                        = 1'b1;
            spec.value                       = fp_fmt_pkg::QNAN;
            spec.flags[fpu_pipe_pkg::FLAG_NV] = 1'b1;
        end else if (a_inf) begin
            spec.take  = 1'b1;
            spec.value = req_i.a;
        end else if (b_inf) begin
            spec.take  = 1'b1;
            spec.value = b_eff;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            stage_o.sign      <= a_ge_b ? req_i.a[31] : b_eff[31];
            stage_o.exp       <= a_ge_b ? ea_eff : eb_eff;
            stage_o.big_sig   <= a_ge_b ? sa : sb;
            stage_o.small_sig <= small_sh;
            stage_o.eff_sub   <= req_i.a[31] ^ b_eff[31];
            stage_o.rm        <= req_i.rm;
            stage_o.spec      <= spec;
        end
    end

endmodule

/* design/fp_add_normalize.sv */
// ==========================================================================
// third adder stage with leading-zero count and normalizing left shift
// ==========================================================================

module fp_add_normalize (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       valid_i,
    input  fpu_pipe_pkg::sum_stage_t   stage_i,
    output logic                       valid_o,
    output fpu_pipe_pkg::norm_stage_t  stage_o
);

    fp_fmt_pkg::exp_t lzc;
    logic             found;

    // scan from the carry bit down
    always_comb begin
        found = 1'b0;
        lzc   = '0;
        for (int i = fp_fmt_pkg::WIDE_W - 1; i >= 0; i--) begin
            if (!found && stage_i.sum[i]) begin
                found = 1'b1;
                lzc   = fp_fmt_pkg::exp_t'(fp_fmt_pkg::WIDE_W - 1 - i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            stage_o.norm  <= stage_i.sum << lzc;
            stage_o.lzc   <= lzc;
            stage_o.carry <= stage_i.sum[fp_fmt_pkg::WIDE_W-1];
            stage_o.zero  <= !found;
            stage_o.sign  <= stage_i.sign;
            stage_o.exp   <= stage_i.exp;
            stage_o.rm    <= stage_i.rm;
            stage_o.spec  <= stage_i.spec;
        end
    end

endmodule

/* design/fp_add_round.sv */
// ==========================================================================
// last adder stage with rounding, exponent adjust, overflow and result select
// ==========================================================================

module fp_add_round (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       valid_i,
    input  fpu_pipe_pkg::norm_stage_t  stage_i,
    output fp_fmt_pkg::fp32_t          result_o,
    output fpu_pipe_pkg::fflags_t      fflags_o,
    output logic                       result_valid_o
);

    fpu_pipe_pkg::norm_stage_t      n_q;
    logic                           valid_q;
    fp_fmt_pkg::sig_t               sig_trunc;
    logic                           lsb;
    logic                           guard;
    logic                           rnd;
    logic                           sticky;
    logic                           inexact;
    logic                           inc;
    logic [fp_fmt_pkg::SIG_W:0]     sig_rnd;
    logic [fp_fmt_pkg::EXP_W+1:0]   exp_full;
    logic                           overflow;
    fp_fmt_pkg::fp32_t              result_d;
    fpu_pipe_pkg::fflags_t          flags_d;

    always_ff @(posedge clk) begin
        if (valid_i) begin
            n_q <= stage_i;
        end
    end

    // leading one sits in the carry position after normalize
    assign sig_trunc = n_q.norm[fp_fmt_pkg::WIDE_W-1 -: fp_fmt_pkg::SIG_W];
    assign lsb       = n_q.norm[fp_fmt_pkg::GRS_W+1];
    assign guard     = n_q.norm[fp_fmt_pkg::GRS_W];
    assign rnd       = n_q.norm[fp_fmt_pkg::GRS_W-1];
    assign sticky    = |n_q.norm[fp_fmt_pkg::GRS_W-2:0];
    assign inexact   = guard | rnd | sticky;

    always_comb begin
        case (n_q.rm)
            fpu_pipe_pkg::RTZ: inc = 1'b0;
            fpu_pipe_pkg::RDN: inc = n_q.sign & inexact;
            fpu_pipe_pkg::RUP: inc = !n_q.sign & inexact;
            fpu_pipe_pkg::RMM: inc = guard;
            default:           inc = guard & (rnd | sticky | lsb);
        endcase
    end

    assign sig_rnd = {1'b0, sig_trunc} + (fp_fmt_pkg::SIG_W + 1)'(inc);

    // mantissa overflow from rounding bumps the exponent
    always_comb begin
        if (n_q.carry) begin
            exp_full = {2'b00, n_q.exp} + (fp_fmt_pkg::EXP_W + 2)'(1);
        end else begin
            exp_full = {2'b00, n_q.exp} + (fp_fmt_pkg::EXP_W + 2)'(1) - {2'b00, n_q.lzc};
        end
        exp_full = exp_full + (fp_fmt_pkg::EXP_W + 2)'(sig_rnd[fp_fmt_pkg::SIG_W]);
    end

    assign overflow = !exp_full[fp_fmt_pkg::EXP_W+1]
                   && (exp_full[fp_fmt_pkg::EXP_W:0] >= {1'b0, fp_fmt_pkg::EXP_MAX});

    // ======================================================================
    // output select
    // ======================================================================
    always_comb begin
        result_d = {n_q.sign, exp_full[fp_fmt_pkg::EXP_W-1:0],
                    sig_rnd[fp_fmt_pkg::MAN_W-1:0]};
        flags_d  = '0;
        flags_d[fpu_pipe_pkg::FLAG_NX] = inexact;
        if (n_q.spec.take) begin
            result_d = n_q.spec.value;
            flags_d  = n_q.spec.flags;
        end else if (n_q.zero) begin
            result_d = '0;
            flags_d  = '0;
        end else if (overflow) begin
            result_d = {n_q.sign, fp_fmt_pkg::EXP_MAX, fp_fmt_pkg::man_t'(0)};
            flags_d[fpu_pipe_pkg::FLAG_OF] = 1'b1;
            flags_d[fpu_pipe_pkg::FLAG_NX] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q        <= 1'b0;
            result_valid_o <= 1'b0;
            result_o       <= '0;
            fflags_o       <= '0;
        end else begin
            valid_q        <= valid_i;
            result_valid_o <= valid_q;
            if (valid_q) begin
                result_o <= result_d;
                fflags_o <= flags_d;
            end
        end
    end

endmodule

/* design/fp_add_sum.sv */
// ==========================================================================
// second adder stage that adds or subtracts the aligned significands
// ==========================================================================

module fp_add_sum (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        valid_i,
    input  fpu_pipe_pkg::align_stage_t  stage_i,
    output logic                        valid_o,
    output fpu_pipe_pkg::sum_stage_t    stage_o
);

    fp_fmt_pkg::wide_t big_w;
    fp_fmt_pkg::wide_t sum_d;

    assign big_w = {1'b0, stage_i.big_sig, {fp_fmt_pkg::GRS_W{1'b0}}};

    // big operand is never smaller, so no borrow out
    assign sum_d = stage_i.eff_sub ? (big_w - stage_i.small_sig)
                                   : (big_w + stage_i.small_sig);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            stage_o.sum  <= sum_d;
            stage_o.sign <= stage_i.sign;
            stage_o.exp  <= stage_i.exp;
            stage_o.rm   <= stage_i.rm;
            stage_o.spec <= stage_i.spec;
        end
    end

endmodule

/* design/fp_fmt_pkg.sv */
// ==========================================================================
// binary32 format package
// field widths, field types and special encodings
// ==========================================================================

package fp_fmt_pkg;

    localparam int EXP_W = 8;
    localparam int MAN_W = 23;
    localparam int SIG_W = 24;
    localparam int GRS_W = 7;

    // carry bit, significand, extra low bits
    localparam int WIDE_W = SIG_W + GRS_W + 1;

    typedef logic [31:0]        fp32_t;
    typedef logic [EXP_W-1:0]   exp_t;
    typedef logic [MAN_W-1:0]   man_t;
    typedef logic [SIG_W-1:0]   sig_t;
    typedef logic [WIDE_W-1:0]  wide_t;

    localparam exp_t  EXP_MAX = '1;
    localparam fp32_t QNAN    = 32'h7FC0_0000;

endpackage

/* design/fpu_ctrl.sv */
// ==========================================================================
// request controller
// holds one operation at a time, decodes the opcode, resolves DYN rounding
// ==========================================================================

module fpu_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid_i,
    input  logic [6:0]              fp_instruction_i,
    input  fpu_pipe_pkg::rm_e       rm_i,
    input  fpu_pipe_pkg::rm_e       csr_rm_i,
    input  fp_fmt_pkg::fp32_t       rs1_i,
    input  fp_fmt_pkg::fp32_t       rs2_i,
    input  logic                    done_i,
    output logic                    req_taken_o,
    output logic                    launch_o,
    output fpu_pipe_pkg::add_req_t  req_o
);

    fpu_pipe_pkg::ctrl_state_e state;
    fpu_pipe_pkg::ctrl_state_e state_nxt;
    logic                      op_add;
    logic                      op_sub;
    logic                      take;

    assign op_add = (fp_instruction_i == {1'b0, fpu_pipe_pkg::OP_ADD});
    assign op_sub = (fp_instruction_i == {1'b0, fpu_pipe_pkg::OP_SUB});

    always_comb begin
        state_nxt = state;
        take      = 1'b0;
        case (state)
            fpu_pipe_pkg::S_IDLE: begin
                take = req_valid_i && (op_add || op_sub);
                if (take) begin
                    state_nxt = fpu_pipe_pkg::S_BUSY;
                end
            end
            fpu_pipe_pkg::S_BUSY: begin
                // next request only in the done cycle
                if (done_i) begin
                    take = req_valid_i && (op_add || op_sub);
                    if (!take) begin
                        state_nxt = fpu_pipe_pkg::S_IDLE;
                    end
                end
            end
            default: state_nxt = fpu_pipe_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fpu_pipe_pkg::S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign req_taken_o = take;
    assign launch_o    = take;

    assign req_o.a   = rs1_i;
    assign req_o.b   = rs2_i;
    assign req_o.sub = op_sub;
    assign req_o.rm  = (rm_i == fpu_pipe_pkg::DYN) ? csr_rm_i : rm_i;

endmodule

/* design/fpu_pipe_pkg.sv */
// ==========================================================================
// FPU pipeline package
// operations, rounding modes, flags, controller states and stage structs
// ==========================================================================

package fpu_pipe_pkg;

    typedef enum logic [5:0] {
        OP_ADD = 6'b000001,
        OP_SUB = 6'b000010
    } fpu_op_e;

    typedef enum logic [2:0] {
        RNE = 3'b000,
        RTZ = 3'b001,
        RDN = 3'b010,
        RUP = 3'b011,
        RMM = 3'b100,
        DYN = 3'b111
    } rm_e;

    // NV DZ OF UF NX from the top bit down
    typedef logic [4:0] fflags_t;

    localparam int FLAG_NV = 4;
    localparam int FLAG_OF = 2;
    localparam int FLAG_NX = 0;

    typedef enum logic {
        S_IDLE,
        S_BUSY
    } ctrl_state_e;

    typedef struct packed {
        fp_fmt_pkg::fp32_t a;
        fp_fmt_pkg::fp32_t b;
        logic              sub;
        rm_e               rm;
    } add_req_t;

    // NaN and infinity results bypass the datapath
    typedef struct packed {
        logic              take;
        fp_fmt_pkg::fp32_t value;
        fflags_t           flags;
    } spec_t;

    typedef struct packed {
        logic               sign;
        fp_fmt_pkg::exp_t   exp;
        fp_fmt_pkg::sig_t   big_sig;
        fp_fmt_pkg::wide_t  small_sig;
        logic               eff_sub;
        rm_e                rm;
        spec_t              spec;
    } align_stage_t;

    typedef struct packed {
        fp_fmt_pkg::wide_t  sum;
        logic               sign;
        fp_fmt_pkg::exp_t   exp;
        rm_e                rm;
        spec_t              spec;
    } sum_stage_t;

    typedef struct packed {
        fp_fmt_pkg::wide_t  norm;
        fp_fmt_pkg::exp_t   lzc;
        logic               carry;
        logic               zero;
        logic               sign;
        fp_fmt_pkg::exp_t   exp;
        rm_e                rm;
        spec_t              spec;
    } norm_stage_t;

endpackage

/* design/fpu_top.sv */
// ==========================================================================
// single-precision add/subtract unit
// request controller in front of a four-stage adder pipeline
// ==========================================================================

module fpu_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid_i,
    input  logic [6:0]             fp_instruction_i,
    input  fpu_pipe_pkg::rm_e      rm_i,
    input  fpu_pipe_pkg::rm_e      csr_rm_i,
    input  fp_fmt_pkg::fp32_t      rs1_i,
    input  fp_fmt_pkg::fp32_t      rs2_i,
    output logic                   req_taken_o,
    output fp_fmt_pkg::fp32_t      result_o,
    output fpu_pipe_pkg::fflags_t  fflags_o,
    output logic                   result_valid_o
);

    logic                        launch;
    fpu_pipe_pkg::add_req_t      req;
    logic                        align_valid;
    fpu_pipe_pkg::align_stage_t  align_stage;
    logic                        sum_valid;
    fpu_pipe_pkg::sum_stage_t    sum_stage;
    logic                        norm_valid;
    fpu_pipe_pkg::norm_stage_t   norm_stage;

    fpu_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .req_valid_i      (req_valid_i),
        .fp_instruction_i (fp_instruction_i),
        .rm_i             (rm_i),
        .csr_rm_i         (csr_rm_i),
        .rs1_i            (rs1_i),
        .rs2_i            (rs2_i),
        .done_i           (result_valid_o),
        .req_taken_o      (req_taken_o),
        .launch_o         (launch),
        .req_o            (req)
    );

    fp_add_align u_align (
        .clk     (clk),
        .rst     (rst),
        .valid_i (launch),
        .req_i   (req),
        .valid_o (align_valid),
        .stage_o (align_stage)
    );

    fp_add_sum u_sum (
        .clk     (clk),
        .rst     (rst),
        .valid_i (align_valid),
        .stage_i (align_stage),
        .valid_o (sum_valid),
        .stage_o (sum_stage)
    );

    fp_add_normalize u_norm (
        .clk     (clk),
        .rst     (rst),
        .valid_i (sum_valid),
        .stage_i (sum_stage),
        .valid_o (norm_valid),
        .stage_o (norm_stage)
    );

    fp_add_round u_round (
        .clk            (clk),
        .rst            (rst),
        .valid_i        (norm_valid),
        .stage_i        (norm_stage),
        .result_o       (result_o),
        .fflags_o       (fflags_o),
        .result_valid_o (result_valid_o)
    );

endmodule

/* sources.f */
+incdir+bench
design/fp_fmt_pkg.sv
design/fpu_pipe_pkg.sv
design/fpu_ctrl.sv
design/fp_add_align.sv
design/fp_add_sum.sv
design/fp_add_normalize.sv
design/fp_add_round.sv
design/fpu_top.sv
bench/tb_fpu.sv
